//--- Bender.yml
package:
  name: memstage

sources:
  - common/isaPkg.sv
  - common/cp0Pkg.sv
  - lsu/lsuLanes.sv
  - exception/excUnit.sv
  - exception/cp0Regs.sv
  - design/stageRegs.sv
  - design/memStage.sv
  - target: simulation
    files:
      - dv/memStage_assertions.sv
      - dv/memStageTb.sv

//--- common/cp0Pkg.sv
`default_nettype none

package cp0Pkg;

    // register numbers as seen in the rd field of MFC0/MTC0
    localparam logic [4:0] Cp0BadVAddr = 5'd8;
    localparam logic [4:0] Cp0Status   = 5'd12;
    localparam logic [4:0] Cp0Cause    = 5'd13;
    localparam logic [4:0] Cp0Epc      = 5'd14;

    // Status
    localparam int StIe   = 0;
    localparam int StExl  = 1;
    localparam int StImLo = 8;    // IM[9:8] software, IM[15:10] hardware
    localparam int StImHi = 15;

    // Cause
    localparam int CaBd    = 31;
    localparam int CaIpLo  = 8;
    localparam int CaIpHi  = 15;
    localparam int CaExcLo = 2;
    localparam int CaExcHi = 6;

endpackage

`default_nettype wire

//--- common/isaPkg.sv
`default_nettype none

package isaPkg;

    // major opcodes
    localparam logic [5:0] OpSpecial = 6'b000000;
    localparam logic [5:0] OpCop0    = 6'b010000;
    localparam logic [5:0] OpLb      = 6'b100000;
    localparam logic [5:0] OpLh      = 6'b100001;
    localparam logic [5:0] OpLw      = 6'b100011;
    localparam logic [5:0] OpLbu     = 6'b100100;
    localparam logic [5:0] OpLhu     = 6'b100101;
    localparam logic [5:0] OpSb      = 6'b101000;
    localparam logic [5:0] OpSh      = 6'b101001;
    localparam logic [5:0] OpSw      = 6'b101011;

    // funct under SPECIAL
    localparam logic [5:0] FnSyscall = 6'b001100;
    localparam logic [5:0] FnBreak   = 6'b001101;

    // rs field picks the COP0 move direction
    localparam logic [4:0] SelMfc0 = 5'b00000;
    localparam logic [4:0] SelMtc0 = 5'b00100;

    localparam logic [31:0] EretWord = 32'h4200_0018;

    // Cause.ExcCode values
    localparam logic [4:0] ExcInt  = 5'd0;
    localparam logic [4:0] ExcAdel = 5'd4;   // load or fetch
    localparam logic [4:0] ExcAdes = 5'd5;   // store
    localparam logic [4:0] ExcSys  = 5'd8;
    localparam logic [4:0] ExcBp   = 5'd9;
    localparam logic [4:0] ExcRi   = 5'd10;
    localparam logic [4:0] ExcOv   = 5'd12;

    // same 32 bits, register form or immediate form
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
    } instrWord_t;

endpackage

`default_nettype wire

//--- design/memStage.sv
`default_nettype none

module memStage #(
    parameter logic [31:0] ExcVector = 32'hBFC0_0380
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        stall,
    input  wire [5:0]  extInt,
    input  wire        exValid,
    input  wire [31:0] exInstr,
    input  wire [31:0] exPc,
    input  wire [31:0] exAddr,        // effective address or MTC0 data
    input  wire [31:0] exStoreData,
    input  wire        exRegWrite,
    input  wire [4:0]  exWreg,
    input  wire        exOverflow,
    input  wire        exInDelaySlot,
    input  wire        exInstrError,
    input  wire [31:0] readData,
    output wire        memEn,
    output wire [3:0]  byteEn,
    output wire [31:0] memWdata,
    output wire [31:0] memAddr,
    output wire        excTaken,
    output wire        redirect,
    output wire [31:0] redirectPc,
    output wire        wbEn,
    output wire [4:0]  wbReg,
    output wire [31:0] wbData
);

    // M stage fields
    wire                     mValid;
    wire isaPkg::instrWord_t mInstr;
    wire [31:0]              mPc;
    wire [31:0]              mAddr;
    wire [31:0]              mStoreData;
    wire                     mRegWrite;
    wire [4:0]               mWreg;
    wire                     mOverflow;
    wire                     mInDelaySlot;
    wire                     mInstrError;

    wire [31:0] loadData;
    wire        addrErrLoad;
    wire        addrErrStore;
    wire [31:0] badAddr;
    wire [4:0]  excCode;
    wire        eretM;
    wire [31:0] status;
    wire [31:0] cause;
    wire [31:0] epc;
    wire [31:0] cp0Data;

    assign memAddr = mAddr;

    stageRegs uStageRegs (.flush(excTaken), .*);   // exception squashes the younger slot

    lsuLanes uLsuLanes (.*);

    excUnit #(.ExcVector(ExcVector)) uExcUnit (.*);

    cp0Regs uCp0Regs (.*);

endmodule

`default_nettype wire

//--- design/stageRegs.sv
`default_nettype none

module stageRegs (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      stall,
    input  wire                      exValid,
    input  wire [31:0]               exInstr,
    input  wire [31:0]               exPc,
    input  wire [31:0]               exAddr,
    input  wire [31:0]               exStoreData,
    input  wire                      exRegWrite,
    input  wire [4:0]                exWreg,
    input  wire                      exOverflow,
    input  wire                      exInDelaySlot,
    input  wire                      exInstrError,
    input  wire                      flush,
    input  wire [31:0]               loadData,
    input  wire [31:0]               cp0Data,
    output logic                     mValid,
    output isaPkg::instrWord_t       mInstr,
    output logic [31:0]              mPc,
    output logic [31:0]              mAddr,
    output logic [31:0]              mStoreData,
    output logic                     mRegWrite,
    output logic [4:0]               mWreg,
    output logic                     mOverflow,
    output logic                     mInDelaySlot,
    output logic                     mInstrError,
    output logic                     wbEn,
    output logic [4:0]               wbReg,
    output logic [31:0]              wbData
);

    logic        isLoad;
    logic        isMfc0;
    logic [31:0] result;

    always_comb begin
        case (mInstr.iType.opcode)
            isaPkg::OpLw, isaPkg::OpLh, isaPkg::OpLhu, isaPkg::OpLb, isaPkg::OpLbu:
                isLoad = 1'b1;
            default:
                isLoad = 1'b0;
        endcase
    end

    assign isMfc0 = mInstr.rType.opcode == isaPkg::OpCop0
                    && mInstr.rType.rs == isaPkg::SelMfc0;
    assign result = isLoad ? loadData : isMfc0 ? cp0Data : mAddr;

    // control bits, a flush turns the incoming slot into a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            mValid       <= 1'b0;
            mRegWrite    <= 1'b0;
            mOverflow    <= 1'b0;
            mInDelaySlot <= 1'b0;
            mInstrError  <= 1'b0;
            wbEn         <= 1'b0;
        end else if (!stall) begin
            mValid       <= exValid & ~flush;
            mRegWrite    <= exRegWrite & ~flush;
            mOverflow    <= exOverflow & ~flush;
            mInDelaySlot <= exInDelaySlot & ~flush;
            mInstrError  <= exInstrError & ~flush;
            wbEn         <= mValid & mRegWrite & ~flush;   // faulting instr never writes back
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            mInstr     <= exInstr;
            mPc        <= exPc;
            mAddr      <= exAddr;
            mStoreData <= exStoreData;
            mWreg      <= exWreg;
            wbReg      <= mWreg;
            wbData     <= result;
        end
    end

endmodule

`default_nettype wire

//--- dv/memStageTb.sv
`default_nettype none

module memStageTb;

    localparam logic [31:0] ExcVector = 32'hBFC0_0380;
    localparam logic [31:0] BasePc = 32'h0040_0100;
    localparam int MaxCycles = 400;   // tests take about 115 cycles

    logic clk, rst, stall, exValid, exRegWrite, exOverflow, exInDelaySlot, exInstrError;
    logic [5:0]  extInt;
    logic [4:0]  exWreg, wreg;
    logic [31:0] exInstr, exPc, exAddr, exStoreData, readData, addr, data, value;
    logic [5:0]  op;
    wire         memEn, excTaken, redirect, wbEn;
    wire  [3:0]  byteEn;
    wire  [4:0]  wbReg;
    wire  [31:0] memWdata, memAddr, redirectPc, wbData;
    int          seed, errors, checks, cycles, wbCount;
    logic [5:0]  storeOps [3] = '{isaPkg::OpSw, isaPkg::OpSh, isaPkg::OpSb};
    logic [5:0]  loadOps [5] = '{isaPkg::OpLw, isaPkg::OpLh, isaPkg::OpLhu, isaPkg::OpLb,
                                 isaPkg::OpLbu};

    memStage #(.ExcVector(ExcVector)) uut (.*);

    bind memStage memStage_assertions #(.ExcVector(ExcVector)) uAssert (
        .clk(clk), .rst(rst), .stall(stall), .mInstr(mInstr), .memEn(memEn), .byteEn(byteEn),
        .memWdata(memWdata), .memAddr(memAddr), .excTaken(excTaken), .redirect(redirect),
        .redirectPc(redirectPc), .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData));

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MaxCycles) begin
            $display("timeout, run did not finish within %0d cycles", MaxCycles);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] cop0Word(input logic [4:0] sel, input logic [4:0] rd);
        return {isaPkg::OpCop0, sel, 5'd2, rd, 11'd0};
    endfunction

    function automatic logic legalAlign(input logic [5:0] op, input logic [1:0] lo);
        if (op == isaPkg::OpLw || op == isaPkg::OpSw) return lo == 2'b00;
        if (op == isaPkg::OpLh || op == isaPkg::OpLhu || op == isaPkg::OpSh) return !lo[0];
        return 1'b1;
    endfunction

    function automatic logic [31:0] expLoad(input logic [5:0] op, input logic [31:0] word,
                                            input logic [1:0] lo);
        logic [31:0] sh;
        sh = word >> (8 * lo);   // addressed lane down to bit 0
        case (op)
            isaPkg::OpLh:  return {{16{sh[15]}}, sh[15:0]};
            isaPkg::OpLhu: return {16'h0, sh[15:0]};
            isaPkg::OpLb:  return {{24{sh[7]}}, sh[7:0]};
            isaPkg::OpLbu: return {24'h0, sh[7:0]};
            default:       return word;
        endcase
    endfunction

    task automatic compareValue(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp)
            else begin
                errors++;
                $display("Error %s expected %h actual %h", name, exp, act);
            end
    endtask

    // drive one instruction and return once it sits in M
    task automatic issue(input logic [31:0] instr, input logic [31:0] pc, input logic [31:0] a,
                         input logic [31:0] d, input logic regWrite, input logic [2:0] flags);
        wreg = $random(seed);
        {exValid, exInstr, exPc, exAddr, exStoreData} = {1'b1, instr, pc, a, d};
        {exRegWrite, exWreg} = {regWrite, wreg};
        {exOverflow, exInDelaySlot, exInstrError} = flags;   // ovf, slot, reserved
        @(negedge clk);
        {exValid, exRegWrite, exOverflow, exInDelaySlot, exInstrError} = 5'b0;
    endtask

    task automatic readCp0(input logic [4:0] rd, output logic [31:0] result);
        issue(cop0Word(isaPkg::SelMfc0, rd), BasePc, 32'h0, 32'h0, 1'b1, 3'b000);
        @(negedge clk);
        compareValue("mfc0 wbEn", 1, wbEn);
        compareValue("mfc0 wbReg", wreg, wbReg);
        result = wbData;
    endtask

    task automatic expectTrap(input string name, input logic [4:0] code, input logic [31:0] bad);
        logic [31:0] r;
        compareValue({name, " excTaken"}, 1, excTaken);
        compareValue({name, " redirectPc"}, ExcVector, redirectPc);
        compareValue({name, " memEn"}, 0, memEn);
        @(negedge clk);
        compareValue({name, " wbEn"}, 0, wbEn);
        readCp0(cp0Pkg::Cp0Cause, r);
        compareValue({name, " cause"}, code, r[cp0Pkg::CaExcHi:cp0Pkg::CaExcLo]);
        if (code == isaPkg::ExcAdel || code == isaPkg::ExcAdes) begin
            readCp0(cp0Pkg::Cp0BadVAddr, r);
            compareValue({name, " badVAddr"}, bad, r);
        end
    endtask

    initial begin
        {clk, rst, stall, extInt, readData, exInstr, exPc, exAddr, exStoreData} = '0;
        {exValid, exRegWrite, exWreg, exOverflow, exInDelaySlot, exInstrError} = '0;
        {errors, checks, cycles} = '0;
        seed = 32'h6a7e_ca07;
        rst = 1'b1;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < 8; i++) begin
            for (int k = 0; k < 4; k++) begin
                op = (i < 3) ? storeOps[i] : loadOps[i - 3];
                addr = ($random(seed) & 32'hFFFF_FFFC) | k;
                data = $random(seed);
                if (legalAlign(op, k)) begin
                    issue({op, 26'd0}, BasePc, addr, data, i >= 3, 3'b000);
                    compareValue("memEn", 1, memEn);
                    compareValue("memAddr", addr, memAddr);
                    if (i == 0) compareValue("sw byteEn", 4'b1111, byteEn);
                    if (i == 0) compareValue("sw memWdata", data, memWdata);
                    if (i == 1) compareValue("sh byteEn", k[1] ? 4'b1100 : 4'b0011, byteEn);
                    if (i == 1) compareValue("sh memWdata", {2{data[15:0]}}, memWdata);
                    if (i == 2) compareValue("sb byteEn", 4'b0001 << k, byteEn);
                    if (i == 2) compareValue("sb memWdata", {4{data[7:0]}}, memWdata);
                    readData = data;
                    @(negedge clk);
                    compareValue("wbEn", i >= 3, wbEn);
                    if (i >= 3) compareValue("load wbReg", wreg, wbReg);
                    if (i >= 3) compareValue("load wbData", expLoad(op, data, k), wbData);
                end
            end
        end
        addr = $random(seed) | 32'h1;
        issue({isaPkg::OpLw, 26'd0}, BasePc, addr, 32'h0, 1'b1, 3'b000);
        expectTrap("lw misaligned", isaPkg::ExcAdel, addr);
        issue({isaPkg::OpSh, 26'd0}, BasePc, addr, 32'h1234, 1'b0, 3'b000);
        expectTrap("sh misaligned", isaPkg::ExcAdes, addr);
        issue({isaPkg::OpLw, 26'd0}, BasePc | 32'h2, addr & ~32'h3, 32'h0, 1'b1, 3'b000);
        expectTrap("pc misaligned", isaPkg::ExcAdel, BasePc | 32'h2);
        issue(32'hFC00_0000, BasePc, 32'h0, 32'h0, 1'b1, 3'b101);
        expectTrap("reserved over overflow", isaPkg::ExcRi, 32'h0);
        issue({26'd0, isaPkg::FnSyscall}, BasePc, 32'h0, 32'h0, 1'b0, 3'b000);
        expectTrap("syscall", isaPkg::ExcSys, 32'h0);
        issue({26'd0, isaPkg::FnBreak}, BasePc, 32'h0, 32'h0, 1'b0, 3'b000);
        expectTrap("break", isaPkg::ExcBp, 32'h0);
        data = $random(seed) & 32'hFFFF_FFFC;
        issue(cop0Word(isaPkg::SelMtc0, cp0Pkg::Cp0Epc), BasePc, data, 32'h0, 1'b0, 3'b000);
        issue(isaPkg::EretWord, BasePc, 32'h0, 32'h0, 1'b0, 3'b000);
        compareValue("eret redirect", 1, redirect);
        compareValue("eret redirectPc", data, redirectPc);
        readCp0(cp0Pkg::Cp0Status, value);
        compareValue("eret exl", 0, value[cp0Pkg::StExl]);
        // IE plus IM[10] for extInt[0]
        issue(cop0Word(isaPkg::SelMtc0, cp0Pkg::Cp0Status), BasePc, 32'h401, 32'h0, 1'b0, 3'b000);
        extInt = 6'b000001;
        issue({26'd0, isaPkg::FnSyscall}, BasePc, 32'h0, 32'h0, 1'b0, 3'b000);
        expectTrap("interrupt", isaPkg::ExcInt, 32'h0);   // EXL now masks it
        issue({isaPkg::OpLw, 26'd0}, BasePc, 32'h100, 32'h0, 1'b0, 3'b000);
        compareValue("exl masks interrupt", 0, excTaken);
        extInt = 6'b000000;
        issue({isaPkg::OpLw, 26'd0}, BasePc, 32'h200, 32'h0, 1'b1, 3'b000);
        readData = $random(seed);
        stall = 1'b1;
        wbCount = 0;
        repeat (4) begin
            @(negedge clk);
            wbCount += wbEn;
        end
        stall = 1'b0;
        repeat (3) begin
            @(negedge clk);
            wbCount += wbEn;
            if (wbEn) compareValue("stall wbData", readData, wbData);
        end
        compareValue("stall writebacks", 1, wbCount);
        issue({26'd0, isaPkg::FnSyscall}, BasePc + 32'h20, 32'h0, 32'h0, 1'b0, 3'b010);
        stall = 1'b1;
        repeat (3) @(negedge clk);
        stall = 1'b0;
        compareValue("stall excTaken", 1, excTaken);
        @(negedge clk);
        readCp0(cp0Pkg::Cp0Epc, value);
        compareValue("stall epc", BasePc + 32'h1C, value);   // slot restarts at the branch
        repeat (2) @(negedge clk);
        errors += uut.uAssert.failCount;
        $display("checks %0d assertion failures %0d errors %0d", checks, uut.uAssert.failCount,
                 errors);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/memStage_assertions.sv
`default_nettype none

module memStage_assertions #(
    parameter logic [31:0] ExcVector = 32'hBFC0_0380
) (
    input wire        clk,
    input wire        rst,
    input wire        stall,
    input wire [31:0] mInstr,
    input wire        memEn,
    input wire [3:0]  byteEn,
    input wire [31:0] memWdata,
    input wire [31:0] memAddr,
    input wire        excTaken,
    input wire        redirect,
    input wire [31:0] redirectPc,
    input wire        wbEn,
    input wire [4:0]  wbReg,
    input wire [31:0] wbData
);

    int failCount = 0;   // summed into the testbench result

    function automatic logic legalLanes(input logic [5:0] op, input logic [3:0] lanes);
        case (op)
            isaPkg::OpSw: return lanes == 4'b1111;
            isaPkg::OpSh: return lanes == 4'b0011 || lanes == 4'b1100;
            isaPkg::OpSb: return $onehot(lanes);
            default:      return 1'b0;
        endcase
    endfunction

    laneLegal: assert property (@(posedge clk) disable iff (rst)
        byteEn == 4'b0000 || legalLanes(mInstr[31:26], byteEn))
        else begin failCount++; $error("byteEn %b illegal for opcode %b", byteEn, mInstr[31:26]); end

    noAccessOnTrap: assert property (@(posedge clk) disable iff (rst)
        excTaken |-> !memEn && byteEn == 4'b0000)
        else begin failCount++; $error("memory access while an exception is taken"); end

    trapVector: assert property (@(posedge clk) disable iff (rst)
        excTaken |-> redirect && redirectPc == ExcVector)
        else begin failCount++; $error("exception redirect to %h", redirectPc); end

    // everything visible must freeze with the pipeline
    holdOnStall: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable({memEn, byteEn, memWdata, memAddr, excTaken, redirect, redirectPc,
                           wbEn, wbReg, wbData}))
        else begin failCount++; $error("outputs moved while stalled"); end

endmodule

`default_nettype wire

//--- exception/cp0Regs.sv
`default_nettype none

module cp0Regs (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     stall,
    input  wire                     mValid,
    input  wire isaPkg::instrWord_t mInstr,
    input  wire [31:0]              mAddr,
    input  wire [31:0]              mPc,
    input  wire                     mInDelaySlot,
    input  wire [31:0]              badAddr,
    input  wire                     excTaken,
    input  wire [4:0]               excCode,
    input  wire                     eretM,
    input  wire [5:0]               extInt,
    output logic [31:0]             status,
    output logic [31:0]             cause,
    output logic [31:0]             epc,
    output logic [31:0]             cp0Data
);

    logic [31:0] badVAddr;
    logic        isMtc0;
    logic        isAddrExc;

    assign isMtc0 = mValid && !excTaken
                    && mInstr.rType.opcode == isaPkg::OpCop0
                    && mInstr.rType.rs == isaPkg::SelMtc0;

    assign isAddrExc = excCode == isaPkg::ExcAdel || excCode == isaPkg::ExcAdes;

    always_ff @(posedge clk) begin
        if (rst) begin
            status   <= 32'h0;
            cause    <= 32'h0;
            epc      <= 32'h0;
            badVAddr <= 32'h0;
        end else if (!stall) begin
            cause[cp0Pkg::CaIpHi:cp0Pkg::CaIpLo+2] <= extInt;   // hardware pending lines
            if (excTaken) begin
                // restart at the branch when the faulting instruction sits in its slot
                epc <= mInDelaySlot ? mPc - 32'd4 : mPc;
                cause[cp0Pkg::CaBd] <= mInDelaySlot;
                cause[cp0Pkg::CaExcHi:cp0Pkg::CaExcLo] <= excCode;
                status[cp0Pkg::StExl] <= 1'b1;
                if (isAddrExc) begin
                    badVAddr <= badAddr;
                end
            end else if (eretM) begin
                status[cp0Pkg::StExl] <= 1'b0;
            end else if (isMtc0) begin
                case (mInstr.rType.rd)
                    cp0Pkg::Cp0Status: status <= mAddr;
                    cp0Pkg::Cp0Cause: begin
                        // only the two software bits are writable
                        cause[cp0Pkg::CaIpLo+1:cp0Pkg::CaIpLo] <=
                            mAddr[cp0Pkg::CaIpLo+1:cp0Pkg::CaIpLo];
                    end
                    cp0Pkg::Cp0Epc:      epc <= mAddr;
                    cp0Pkg::Cp0BadVAddr: badVAddr <= mAddr;
                    default: ;
                endcase
            end
        end
    end

    // MFC0 read port, selected by rd
    always_comb begin
        case (mInstr.rType.rd)
            cp0Pkg::Cp0Status:   cp0Data = status;
            cp0Pkg::Cp0Cause:    cp0Data = cause;
            cp0Pkg::Cp0Epc:      cp0Data = epc;
            cp0Pkg::Cp0BadVAddr: cp0Data = badVAddr;
            default:             cp0Data = 32'h0;
        endcase
    end

endmodule

`default_nettype wire

//--- exception/excUnit.sv
`default_nettype none

module excUnit #(
    parameter logic [31:0] ExcVector = 32'hBFC0_0380
) (
    input  wire                     mValid,
    input  wire isaPkg::instrWord_t mInstr,
    input  wire                     mOverflow,
    input  wire                     mInstrError,
    input  wire                     addrErrLoad,
    input  wire                     addrErrStore,
    input  wire [5:0]               extInt,
    input  wire [31:0]              status,
    input  wire [31:0]              cause,
    input  wire [31:0]              epc,
    output logic                    excTaken,
    output logic [4:0]              excCode,
    output logic                    eretM,
    output logic                    redirect,
    output logic [31:0]             redirectPc
);

    logic swInt;
    logic hwInt;
    logic intPending;
    logic isSpecial;
    logic isSyscall;
    logic isBreak;

    // IP[9:8] are written by software, the upper six come straight from the pins
    assign swInt = |(status[cp0Pkg::StImLo+1:cp0Pkg::StImLo]
                     & cause[cp0Pkg::CaIpLo+1:cp0Pkg::CaIpLo]);
    assign hwInt = |(status[cp0Pkg::StImHi:cp0Pkg::StImLo+2] & extInt);
    assign intPending = status[cp0Pkg::StIe] & ~status[cp0Pkg::StExl] & (swInt | hwInt);

    assign isSpecial = mInstr.rType.opcode == isaPkg::OpSpecial;
    assign isSyscall = isSpecial && mInstr.rType.funct == isaPkg::FnSyscall;
    assign isBreak   = isSpecial && mInstr.rType.funct == isaPkg::FnBreak;

    // highest priority first
    assign excCode = intPending   ? isaPkg::ExcInt  :
                     addrErrLoad  ? isaPkg::ExcAdel :
                     addrErrStore ? isaPkg::ExcAdes :
                     isSyscall    ? isaPkg::ExcSys  :
                     isBreak      ? isaPkg::ExcBp   :
                     mInstrError  ? isaPkg::ExcRi   :
                                    isaPkg::ExcOv;

    assign excTaken = mValid & (intPending | addrErrLoad | addrErrStore | isSyscall
                                | isBreak | mInstrError | mOverflow);

    // an ERET that faults is just an exception
    assign eretM = mValid && (mInstr == isaPkg::EretWord) && !excTaken;

    assign redirect   = excTaken | eretM;
    assign redirectPc = excTaken ? ExcVector : epc;

endmodule

`default_nettype wire

//--- lsu/lsuLanes.sv
`default_nettype none

module lsuLanes (
    input  wire                     mValid,
    input  wire isaPkg::instrWord_t mInstr,
    input  wire [31:0]              mAddr,
    input  wire [31:0]              mStoreData,
    input  wire [31:0]              mPc,
    input  wire [31:0]              readData,
    input  wire                     excTaken,
    output logic                    memEn,
    output logic [3:0]              byteEn,
    output logic [31:0]             memWdata,
    output logic [31:0]             loadData,
    output logic                    addrErrLoad,
    output logic                    addrErrStore,
    output logic [31:0]             badAddr
);

    logic [5:0]  op;
    logic        isLoad;
    logic        isStore;
    logic        misaligned;
    logic        pcErr;
    logic [3:0]  laneMask;
    logic [15:0] halfSel;
    logic [7:0]  byteSel;

    assign op = mInstr.iType.opcode;

    // store steering and access class
    always_comb begin
        isLoad   = 1'b0;
        isStore  = 1'b0;
        laneMask = 4'b0000;
        memWdata = 32'h0;
        case (op)
            isaPkg::OpLw, isaPkg::OpLh, isaPkg::OpLhu, isaPkg::OpLb, isaPkg::OpLbu: begin
                isLoad = 1'b1;
            end
            isaPkg::OpSw: begin
                isStore  = 1'b1;
                laneMask = 4'b1111;
                memWdata = mStoreData;
            end
            isaPkg::OpSh: begin
                isStore  = 1'b1;
                laneMask = mAddr[1] ? 4'b1100 : 4'b0011;
                memWdata = {2{mStoreData[15:0]}};   // same half on both lanes
            end
            isaPkg::OpSb: begin
                isStore  = 1'b1;
                laneMask = 4'b0001 << mAddr[1:0];
                memWdata = {4{mStoreData[7:0]}};
            end
            default: ;
        endcase
    end

    assign halfSel = mAddr[1] ? readData[31:16] : readData[15:0];
    assign byteSel = readData[{mAddr[1:0], 3'b000} +: 8];

    always_comb begin
        case (op)
            isaPkg::OpLw:  loadData = readData;
            isaPkg::OpLh:  loadData = {{16{halfSel[15]}}, halfSel};
            isaPkg::OpLhu: loadData = {16'h0, halfSel};
            isaPkg::OpLb:  loadData = {{24{byteSel[7]}}, byteSel};
            isaPkg::OpLbu: loadData = {24'h0, byteSel};
            default:       loadData = 32'h0;
        endcase
    end

    // alignment rules, bytes never fault
    always_comb begin
        case (op)
            isaPkg::OpLw, isaPkg::OpSw:                misaligned = |mAddr[1:0];
            isaPkg::OpLh, isaPkg::OpLhu, isaPkg::OpSh: misaligned = mAddr[0];
            default:                                   misaligned = 1'b0;
        endcase
    end

    assign pcErr        = mValid && (mPc[1:0] != 2'b00);
    assign addrErrLoad  = pcErr | (mValid & isLoad & misaligned);   // fetch error reported as AdEL
    assign addrErrStore = mValid & isStore & misaligned;
    assign badAddr      = pcErr ? mPc : mAddr;

    assign memEn  = mValid & (isLoad | isStore) & ~excTaken;
    assign byteEn = (mValid & isStore & ~excTaken) ? laneMask : 4'b0000;

endmodule

`default_nettype wire

//--- vlog.f
common/isaPkg.sv
common/cp0Pkg.sv
lsu/lsuLanes.sv
exception/excUnit.sv
exception/cp0Regs.sv
design/stageRegs.sv
design/memStage.sv
dv/memStage_assertions.sv
dv/memStageTb.sv
